/* compile.f */
src/pkt_pkg.sv
src/sync_fifo.sv
src/pkt_ingress_tracker.sv
src/pkt_framer.sv
src/stream_packetizer.sv
tests/tb_stream_packetizer.sv

/* Bender.yml */
package:
  name: stream_packetizer

sources:
  - src/pkt_pkg.sv
  - src/sync_fifo.sv
  - src/pkt_ingress_tracker.sv
  - src/pkt_framer.sv
  - src/stream_packetizer.sv
  - target: test
    files:
      - tests/tb_stream_packetizer.sv

/* tests/tb_stream_packetizer.sv */
// Self-checking testbench for the packetizer; compile with compile.f, top is tb_stream_packetizer
`timescale 1ns/1ps
`default_nettype none

module tb_stream_packetizer;

   import pkt_pkg::*;

   localparam int          CLK_PERIOD = 40;
   localparam logic [31:0] SEED       = 32'h473807f0;

   // One test row: stimulus settings, then hand-counted expectations
   typedef struct packed {
      logic [13:0] packet_size;
      logic [47:0] burst_size;
      logic [63:0] start_time;
      logic [15:0] time_per_pkt;
      logic [31:0] flow_id;
      logic [15:0] n_samples;
      logic [15:0] exp_pkts;
      logic [15:0] exp_eob;
   } row_t;

   localparam int N_ROWS = 6;
   // size, burst, start time, step, flow id, samples, packets, EOB packets
   localparam row_t ROWS [N_ROWS] = '{
      '{14'd8, 48'd32, 64'h0000_0000_0000_1000, 16'h0040, 32'ha5a5_0001, 16'd64, 16'd8, 16'd2},
      // Odd size, stamp wraps past the top of the 64-bit range
      '{14'd5, 48'd15, 64'hffff_ffff_ffff_ff00, 16'h0100, 32'h0000_0002, 16'd30, 16'd6, 16'd2},
      '{14'd4, 48'd0, 64'h0000_0012_3456_7890, 16'hffff, 32'h1234_0003, 16'd40, 16'd10, 16'd0},
      // Long infinite burst, sequence id wraps at 256
      '{14'd2, 48'd0, 64'h0000_0000_0000_0000, 16'h0003, 32'h0bad_0004, 16'd600, 16'd300, 16'd0},
      '{14'd1, 48'd3, 64'h8000_0000_0000_0001, 16'h0010, 32'h0000_0005, 16'd9, 16'd9, 16'd3},
      // Every packet a burst of its own
      '{14'd7, 48'd7, 64'h0000_00ff_0000_0000, 16'h0200, 32'hcafe_0006, 16'd21, 16'd3, 16'd3}
   };

   logic         clk;
   logic         rst;
   logic         enable;
   pkt_time_t    start_time;
   pkt_size_t    packet_size;
   flow_id_t     flow_id;
   time_incr_t   time_per_pkt;
   burst_count_t burst_size;
   sample_t      in_tdata;
   logic         in_tvalid;
   logic         in_tready;
   word_t        out_tdata;
   logic         out_tvalid;
   logic         out_tlast;
   logic         out_tready;
   logic         idle;

   // Expected output words, tlast on top
   logic [64:0]  exp_q [$];
   sample_t      samples [$];
   logic [64:0]  head;
   logic [31:0]  stim_state;
   logic [31:0]  ready_state;
   int           pkt_count;
   int           eob_count;
   logic         at_header;

   // Small buffers so back-pressure reaches the input
   stream_packetizer #(
      .TIME_FIFO_DEPTH_LOG2   (2),
      .SAMPLE_FIFO_DEPTH_LOG2 (4)
   ) u_stream_packetizer (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .start_time   (start_time),
      .packet_size  (packet_size),
      .flow_id      (flow_id),
      .time_per_pkt (time_per_pkt),
      .burst_size   (burst_size),
      .in_tdata     (in_tdata),
      .in_tvalid    (in_tvalid),
      .in_tready    (in_tready),
      .out_tdata    (out_tdata),
      .out_tvalid   (out_tvalid),
      .out_tlast    (out_tlast),
      .out_tready   (out_tready),
      .idle         (idle)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ----------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic fail_with(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Stopped on error");
   endtask

   // Expected words of one row: header, time, then sample pairs
   task automatic build_expected(input row_t r);
      int          n_pkts;
      int          p;
      int          i;
      int          first;
      int          last;
      logic        eob;
      logic [7:0]  type_code;
      pkt_time_t   stamp;
      word_t       word;
      n_pkts = r.n_samples / r.packet_size;
      stamp  = r.start_time;
      for (p = 0; p < n_pkts; p++) begin
         first = p * r.packet_size;
         last  = first + r.packet_size - 1;
         // First packet of a burst takes start_time, others step on
         if (p == 0 || (r.burst_size != 0 && (48'(first) % r.burst_size) == 48'd0)) begin
            stamp = r.start_time;
         end else begin
            stamp = stamp + 64'(r.time_per_pkt);
         end
         eob = (r.burst_size != 0) && ((48'(last + 1) % r.burst_size) == 48'd0);
         type_code = eob ? INT16_COMPLEX_EOB : INT16_COMPLEX;
         word = {type_code, p[7:0], r.packet_size + 14'd4, 2'b00, r.flow_id};
         exp_q.push_back({1'b0, word});
         exp_q.push_back({1'b0, stamp});
         for (i = first; i <= last; i += 2) begin
            // Unpaired tail sample fills both halves
            if (i + 1 <= last) begin
               word = {samples[i], samples[i + 1]};
            end else begin
               word = {samples[i], samples[i]};
            end
            exp_q.push_back({(i + 1 >= last), word});
         end
      end
   endtask

   // Sends n samples with random valid gaps
   task automatic drive_samples(input int n);
      int idx;
      idx = 0;
      while (idx < n) begin
         @(posedge clk);
         if (in_tvalid && in_tready) begin
            idx++;
         end
         // A refused beat stays on the bus
         if (!(in_tvalid && !in_tready)) begin
            stim_state = lcg_next(stim_state);
            if (idx < n && stim_state[31:30] != 2'b00) begin
               in_tvalid <= 1'b1;
               in_tdata  <= samples[idx];
            end else begin
               in_tvalid <= 1'b0;
            end
         end
      end
   endtask

   task automatic run_row(input row_t r);
      int i;
      @(posedge clk);
      packet_size  <= r.packet_size;
      burst_size   <= r.burst_size;
      start_time   <= r.start_time;
      time_per_pkt <= r.time_per_pkt;
      flow_id      <= r.flow_id;
      samples.delete();
      for (i = 0; i < r.n_samples; i++) begin
         stim_state = lcg_next(stim_state);
         samples.push_back(stim_state);
      end
      build_expected(r);
      pkt_count = 0;
      eob_count = 0;
      // Burst counter reloads and seq id clears while disabled
      repeat (3) @(posedge clk);
      enable <= 1'b1;
      drive_samples(r.n_samples);
      enable <= 1'b0;
      repeat (2) @(posedge clk);
      while (!idle) begin
         @(posedge clk);
      end
      check_value("pending words", 64'(exp_q.size()), 64'd0);
      check_value("packet count", 64'(pkt_count), 64'(r.exp_pkts));
      check_value("eob packet count", 64'(eob_count), 64'(r.exp_eob));
   endtask

   // ----------------------------------------------------------
   // Output side: random ready and beat checking
   // ----------------------------------------------------------
   always @(posedge clk) begin
      ready_state = lcg_next(ready_state);
      out_tready <= (ready_state[31:30] != 2'b00);
   end

   always @(posedge clk) begin
      // Input is refused while disabled
      if (!rst && !enable) begin
         check_value("in_tready", 64'(in_tready), 64'd0);
      end
      if (!rst && out_tvalid && out_tready) begin
         if (exp_q.size() == 0) begin
            fail_with("Output word arrived with nothing left to expect");
         end else begin
            head = exp_q.pop_front();
            check_value("out_tdata", out_tdata, head[63:0]);
            check_value("out_tlast", 64'(out_tlast), 64'(head[64]));
            if (at_header && out_tdata[63:56] == INT16_COMPLEX_EOB) begin
               eob_count++;
            end
            if (out_tlast) begin
               pkt_count++;
            end
            // Word after tlast is the next header
            at_header = out_tlast;
         end
      end
   end

   // ----------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------
   initial begin
      int row;
      rst          = 1'b1;
      enable       = 1'b0;
      start_time   = '0;
      packet_size  = 14'd2;
      flow_id      = '0;
      time_per_pkt = '0;
      burst_size   = '0;
      in_tdata     = '0;
      in_tvalid    = 1'b0;
      out_tready   = 1'b0;
      stim_state   = SEED;
      ready_state  = SEED ^ 32'h9e37_79b9;
      pkt_count    = 0;
      eob_count    = 0;
      at_header    = 1'b1;
      repeat (4) @(posedge clk);
      // Nothing accepted or offered straight after reset
      check_value("in_tready", 64'(in_tready), 64'd0);
      check_value("out_tvalid", 64'(out_tvalid), 64'd0);
      check_value("idle", 64'(idle), 64'd1);
      rst <= 1'b0;
      for (row = 0; row < N_ROWS; row++) begin
         run_row(ROWS[row]);
      end
      $display("TEST PASS");
      $finish;
   end

   // Budget of 8 cycles per sample plus slack for setup and draining
   initial begin
      int total;
      int k;
      total = 0;
      for (k = 0; k < N_ROWS; k++) begin
         total += ROWS[k].n_samples;
      end
      repeat (8 * total + 2000) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", 8 * total + 2000);
      $display("TEST FAIL");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire

/* src/stream_packetizer.sv */
// Top level packetizer; turns a complex sample stream into framed 64-bit packets
`timescale 1ns/1ps
`default_nettype none

module stream_packetizer #(
   parameter int TIME_FIFO_DEPTH_LOG2   = 4,
   parameter int SAMPLE_FIFO_DEPTH_LOG2 = 8
) (
   input  wire logic                  clk,
   input  wire logic                  rst,
   // Control levels, steady while enabled
   input  wire logic                  enable,
   input  wire pkt_pkg::pkt_time_t    start_time,
   input  wire pkt_pkg::pkt_size_t    packet_size,
   input  wire pkt_pkg::flow_id_t     flow_id,
   input  wire pkt_pkg::time_incr_t   time_per_pkt,
   input  wire pkt_pkg::burst_count_t burst_size,
   // Sample stream in
   input  wire pkt_pkg::sample_t      in_tdata,
   input  wire logic                  in_tvalid,
   output logic                       in_tready,
   // Packet stream out
   output pkt_pkg::word_t             out_tdata,
   output logic                       out_tvalid,
   output logic                       out_tlast,
   input  wire logic                  out_tready,
   output logic                       idle
);

   import pkt_pkg::*;

   logic [SAMPLE_ENTRY_W-1:0] sfifo_wr_data;
   logic                      sfifo_wr_valid;
   logic                      sfifo_not_full;
   logic [SAMPLE_ENTRY_W-1:0] sfifo_rd_data;
   logic                      sfifo_rd_valid;
   logic                      sfifo_rd_pop;

   logic [TIME_ENTRY_W-1:0]   tfifo_wr_data;
   logic                      tfifo_wr_valid;
   logic                      tfifo_not_full;
   logic [TIME_ENTRY_W-1:0]   tfifo_rd_data;
   logic                      tfifo_rd_valid;
   logic                      tfifo_rd_pop;

   logic                      ingress_idle;

   // ----------------------------------------------------------
   // Ingress tracking
   // ----------------------------------------------------------
   pkt_ingress_tracker u_tracker (
      .clk            (clk),
      .rst            (rst),
      .enable         (enable),
      .in_tdata       (in_tdata),
      .in_tvalid      (in_tvalid),
      .in_tready      (in_tready),
      .start_time     (start_time),
      .time_per_pkt   (time_per_pkt),
      .packet_size    (packet_size),
      .burst_size     (burst_size),
      .sfifo_not_full (sfifo_not_full),
      .tfifo_not_full (tfifo_not_full),
      .sfifo_wr_data  (sfifo_wr_data),
      .sfifo_wr_valid (sfifo_wr_valid),
      .tfifo_wr_data  (tfifo_wr_data),
      .tfifo_wr_valid (tfifo_wr_valid),
      .ingress_idle   (ingress_idle)
   );

   // ----------------------------------------------------------
   // Sample and time buffers
   // ----------------------------------------------------------
   sync_fifo #(
      .WIDTH      (SAMPLE_ENTRY_W),
      .DEPTH_LOG2 (SAMPLE_FIFO_DEPTH_LOG2)
   ) u_sample_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_data  (sfifo_wr_data),
      .wr_valid (sfifo_wr_valid),
      .not_full (sfifo_not_full),
      .rd_data  (sfifo_rd_data),
      .rd_valid (sfifo_rd_valid),
      .rd_pop   (sfifo_rd_pop)
   );

   // One entry per buffered packet
   sync_fifo #(
      .WIDTH      (TIME_ENTRY_W),
      .DEPTH_LOG2 (TIME_FIFO_DEPTH_LOG2)
   ) u_time_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_data  (tfifo_wr_data),
      .wr_valid (tfifo_wr_valid),
      .not_full (tfifo_not_full),
      .rd_data  (tfifo_rd_data),
      .rd_valid (tfifo_rd_valid),
      .rd_pop   (tfifo_rd_pop)
   );

   // ----------------------------------------------------------
   // Packet framing
   // ----------------------------------------------------------
   pkt_framer u_framer (
      .clk            (clk),
      .rst            (rst),
      .enable         (enable),
      .flow_id        (flow_id),
      .tfifo_rd_data  (tfifo_rd_data),
      .tfifo_rd_valid (tfifo_rd_valid),
      .tfifo_rd_pop   (tfifo_rd_pop),
      .sfifo_rd_data  (sfifo_rd_data),
      .sfifo_rd_valid (sfifo_rd_valid),
      .sfifo_rd_pop   (sfifo_rd_pop),
      .ingress_idle   (ingress_idle),
      .out_tdata      (out_tdata),
      .out_tvalid     (out_tvalid),
      .out_tlast      (out_tlast),
      .out_tready     (out_tready),
      .idle           (idle)
   );

endmodule

`default_nettype wire

/* src/pkt_framer.sv */
// Output framing FSM; pops time and sample FIFOs and drives header, time and sample words
`timescale 1ns/1ps
`default_nettype none

module pkt_framer (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             enable,
   input  wire pkt_pkg::flow_id_t                flow_id,
   input  wire logic [pkt_pkg::TIME_ENTRY_W-1:0] tfifo_rd_data,
   input  wire logic                             tfifo_rd_valid,
   output logic                                  tfifo_rd_pop,
   input  wire logic [pkt_pkg::SAMPLE_ENTRY_W-1:0] sfifo_rd_data,
   input  wire logic                             sfifo_rd_valid,
   output logic                                  sfifo_rd_pop,
   input  wire logic                             ingress_idle,
   output pkt_pkg::word_t                        out_tdata,
   output logic                                  out_tvalid,
   output logic                                  out_tlast,
   input  wire logic                             out_tready,
   output logic                                  idle
);

   import pkt_pkg::*;

   typedef enum logic [1:0] {
      OUT_HEADER,
      OUT_TIME,
      OUT_SAMPLES
   } out_state_t;

   out_state_t out_state;
   seq_id_t    seq_id;
   pkt_type_t  pkt_type;
   logic       out_beat;

   // Time entry fields
   assign pkt_type = tfifo_rd_data[78] ? INT16_COMPLEX_EOB : INT16_COMPLEX;
   assign out_beat = out_tvalid && out_tready;

   // ----------------------------------------------------------
   // Output sequence
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         out_state <= OUT_HEADER;
      end else if (out_beat) begin
         case (out_state)
            OUT_HEADER:  out_state <= OUT_TIME;
            OUT_TIME:    out_state <= OUT_SAMPLES;
            OUT_SAMPLES: begin
               if (out_tlast) begin
                  out_state <= OUT_HEADER;
               end
            end
            default:     out_state <= OUT_HEADER;
         endcase
      end
   end

   // Word mux and FIFO pops
   always_comb begin
      out_tdata    = '0;
      out_tvalid   = 1'b0;
      out_tlast    = 1'b0;
      tfifo_rd_pop = 1'b0;
      sfifo_rd_pop = 1'b0;
      case (out_state)
         OUT_HEADER: begin
            // Type, seq id, size, two zero bits, flow id
            out_tdata  = {pkt_type, seq_id, tfifo_rd_data[77:64], 2'b00, flow_id};
            out_tvalid = tfifo_rd_valid;
         end
         OUT_TIME: begin
            // Time entry retires with the time word
            out_tdata    = tfifo_rd_data[63:0];
            out_tvalid   = tfifo_rd_valid;
            tfifo_rd_pop = tfifo_rd_valid && out_tready;
         end
         OUT_SAMPLES: begin
            out_tdata    = sfifo_rd_data[63:0];
            out_tvalid   = sfifo_rd_valid;
            out_tlast    = sfifo_rd_data[64];
            sfifo_rd_pop = sfifo_rd_valid && out_tready;
         end
         default: begin
            out_tvalid = 1'b0;
         end
      endcase
   end

   // ----------------------------------------------------------
   // Sequence id and idle flag
   // ----------------------------------------------------------
   // Clears once disabled and drained, so queued packets keep their ids
   always_ff @(posedge clk) begin
      if (rst) begin
         seq_id <= '0;
      end else if (!enable && idle) begin
         seq_id <= '0;
      end else if (out_beat && out_tlast) begin
         seq_id <= seq_id + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         idle <= 1'b1;
      end else begin
         idle <= !out_tvalid && !enable && !tfifo_rd_valid && ingress_idle;
      end
   end

   // Stalled word holds until taken
   a_hold_stall : assert property (@(posedge clk) disable iff (rst)
      (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata) && $stable(out_tlast)));

endmodule

`default_nettype wire

/* src/pkt_ingress_tracker.sv */
// Ingress side of the packetizer; pairs samples, counts packets and bursts, feeds both FIFOs
`timescale 1ns/1ps
`default_nettype none

module pkt_ingress_tracker (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             enable,
   input  wire pkt_pkg::sample_t                 in_tdata,
   input  wire logic                             in_tvalid,
   output logic                                  in_tready,
   input  wire pkt_pkg::pkt_time_t               start_time,
   input  wire pkt_pkg::time_incr_t              time_per_pkt,
   input  wire pkt_pkg::pkt_size_t               packet_size,
   input  wire pkt_pkg::burst_count_t            burst_size,
   input  wire logic                             sfifo_not_full,
   input  wire logic                             tfifo_not_full,
   output logic [pkt_pkg::SAMPLE_ENTRY_W-1:0]    sfifo_wr_data,
   output logic                                  sfifo_wr_valid,
   output logic [pkt_pkg::TIME_ENTRY_W-1:0]      tfifo_wr_data,
   output logic                                  tfifo_wr_valid,
   output logic                                  ingress_idle
);

   import pkt_pkg::*;

   typedef enum logic [1:0] {
      IN_IDLE,
      IN_PHASE1,
      IN_PHASE2
   } in_state_t;

   typedef enum logic {
      BURST_NEW,
      BURST_ACTIVE
   } burst_state_t;

   in_state_t    in_state;
   burst_state_t burst_state;

   logic         beat;
   logic         end_of_packet;
   logic         end_of_burst;
   logic         odd_tail;
   // Sample count in the current packet, including the sample on the bus
   pkt_size_t    in_count;
   pkt_size_t    size_field;
   // Samples left in the burst, including the sample on the bus
   burst_count_t burst_left;
   sample_t      hold;
   pkt_time_t    packet_time;
   pkt_time_t    cur_time;

   // Accept only when enabled and both buffers have room
   assign in_tready = enable && sfifo_not_full && tfifo_not_full;
   assign beat      = in_tvalid && in_tready;

   assign end_of_packet = (in_count >= packet_size);
   // Zero burst size never ends a burst
   assign end_of_burst  = (burst_left <= burst_count_t'(packet_size)) && (burst_size != '0);
   // Odd packet closes with an unpaired sample
   assign odd_tail      = end_of_packet && in_count[0];

   assign ingress_idle = (in_state == IN_IDLE) && (burst_state == BURST_NEW);

   // ----------------------------------------------------------
   // Sample pairing and packet counting
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         in_state <= IN_IDLE;
         in_count <= 14'd1;
      end else if (beat) begin
         if (end_of_packet) begin
            in_state <= IN_IDLE;
            in_count <= 14'd1;
         end else begin
            // First of a pair goes to the holding register
            in_state <= (in_state == IN_PHASE2) ? IN_PHASE1 : IN_PHASE2;
            in_count <= in_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         hold <= in_tdata;
      end
   end

   // ----------------------------------------------------------
   // Burst tracking
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         burst_state <= BURST_NEW;
         burst_left  <= burst_size;
      end else if (!enable) begin
         // Next enable starts a fresh burst
         burst_state <= BURST_NEW;
         burst_left  <= burst_size;
      end else if (beat) begin
         if (burst_size != '0) begin
            burst_left <= burst_left - 1'b1;
         end
         if (burst_left == burst_count_t'(1)) begin
            burst_state <= BURST_NEW;
            burst_left  <= burst_size;
         end else begin
            burst_state <= BURST_ACTIVE;
         end
      end
   end

   // ----------------------------------------------------------
   // Packet timestamp
   // ----------------------------------------------------------
   // Stamp for the packet the current beat belongs to
   always_comb begin
      cur_time = packet_time;
      if (in_state == IN_IDLE) begin
         if (burst_state == BURST_NEW) begin
            cur_time = start_time;
         end else begin
            cur_time = packet_time + pkt_time_t'(time_per_pkt);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         packet_time <= cur_time;
      end
   end

   // ----------------------------------------------------------
   // FIFO writes
   // ----------------------------------------------------------
   // Earlier sample sits in the upper half
   assign sfifo_wr_data  = {end_of_packet, (odd_tail ? in_tdata : hold), in_tdata};
   assign sfifo_wr_valid = beat && ((in_state == IN_PHASE2) || odd_tail);

   // Size in 32-bit units, header and time included
   assign size_field     = in_count + HDR_SIZE_WORDS;
   assign tfifo_wr_data  = {end_of_burst, size_field, cur_time};
   assign tfifo_wr_valid = beat && end_of_packet;

   // Last sample of a burst must also close a packet
   a_burst_on_packet_end : assert property (@(posedge clk) disable iff (rst)
      (beat && (burst_size != '0) && (burst_left == burst_count_t'(1))) |-> end_of_packet);

endmodule

`default_nettype wire

/* src/sync_fifo.sv */
// Synchronous show-ahead FIFO; instantiate with WIDTH and DEPTH_LOG2 for sample and time buffers
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_LOG2 = 4
) (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire logic [WIDTH-1:0] wr_data,
   input  wire logic             wr_valid,
   output logic                  not_full,
   output logic [WIDTH-1:0]      rd_data,
   output logic                  rd_valid,
   input  wire logic             rd_pop
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   // Storage, no reset on the array
   logic [WIDTH-1:0] mem [DEPTH];

   // One extra pointer bit tells full from empty
   logic [DEPTH_LOG2:0] wr_ptr;
   logic [DEPTH_LOG2:0] rd_ptr;
   logic                full;
   logic                empty;
   logic                do_write;
   logic                do_read;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

   assign not_full = !full;
   assign rd_valid = !empty;

   // Head entry shown combinationally
   assign rd_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

   // Writes into a full buffer are dropped
   assign do_write = wr_valid && !full;
   assign do_read  = rd_pop && !empty;

   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Producer must watch not_full
   a_no_write_full : assert property (@(posedge clk) disable iff (rst) !(wr_valid && full));
   // Consumer must only pop a shown entry
   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst) !(rd_pop && empty));

endmodule

`default_nettype wire

/* src/pkt_pkg.sv */
// Shared packet types, field widths and header constants; import into any packetizer block
`default_nettype none

package pkt_pkg;

   // ----------------------------------------------------------
   // Data types
   // ----------------------------------------------------------

   // One complex sample, I in bits 31..16, Q in bits 15..0
   typedef logic [31:0] sample_t;
   // Output word and sample FIFO payload
   typedef logic [63:0] word_t;
   typedef logic [63:0] pkt_time_t;
   // Packet size in samples, also the header size field in 32-bit units
   typedef logic [13:0] pkt_size_t;
   typedef logic [47:0] burst_count_t;
   typedef logic [31:0] flow_id_t;
   typedef logic [15:0] time_incr_t;
   typedef logic [7:0]  seq_id_t;

   // Packet type opcodes in header bits 63..56
   typedef enum logic [7:0] {
      INT16_COMPLEX     = 8'h10,
      INT16_COMPLEX_EOB = 8'h11
   } pkt_type_t;

   // ----------------------------------------------------------
   // Header and buffer constants
   // ----------------------------------------------------------

   // Header word plus time word, counted in 32-bit units
   localparam pkt_size_t HDR_SIZE_WORDS = 14'd4;

   // tlast flag on top of a sample pair word
   localparam int SAMPLE_ENTRY_W = 65;
   // EOB flag, size field, then timestamp
   localparam int TIME_ENTRY_W = 79;

endpackage

`default_nettype wire
